// ==== sources.f ====
+incdir+.
satd_pkg.sv
row_pair_if.sv
blk_ctrl.sv
cur_blk_buf.sv
candi_lane.sv
hadamard_row8.sv
satd_8x8.sv
fme_satd_gen.sv
tb_fme_satd_gen.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the fme satd testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sources.f \
    --top-module tb_fme_satd_gen -o tb_fme_satd_gen
./obj_dir/tb_fme_satd_gen > sim.log 2>&1
cat sim.log

if grep -q "RESULT: PASS" sim.log; then
    exit 0
fi
exit 1

// ==== tb_satd_model.svh ====
// *******************************************************************
// reference model of the fme satd stage for the testbench
// direct 8x8 hadamard satd and zig-zag to raster address
// *******************************************************************
`ifndef TB_SATD_MODEL_SVH
`define TB_SATD_MODEL_SVH

typedef int blk_t [8][8];

// walsh basis sign, -1 for an odd number of common bits
function automatic int walsh_sign(input int a, input int b);
    return ($countones(a & b) % 2 != 0) ? -1 : 1;
endfunction

// full 2-d transform of the difference, then (sum |coef| + 2) >> 2
function automatic int satd_ref(input blk_t cur, input blk_t cand);
    int sum;
    int coef;
    sum = 0;
    for (int j = 0; j < 8; j++) begin
        for (int k = 0; k < 8; k++) begin
            coef = 0;
            for (int r = 0; r < 8; r++) begin
                for (int c = 0; c < 8; c++) begin
                    coef += walsh_sign(j, r) * walsh_sign(k, c) * (cand[r][c] - cur[r][c]);
                end
            end
            sum += (coef < 0) ? -coef : coef;
        end
    end
    return (sum + 2) >> 2;
endfunction

// quadrants of 32, 16 and 8 pixels, quadrant 1 to the right and 2 below
// result is {x, y} in 4x4 units
function automatic logic [7:0] zigzag_xy(input logic [5:0] idx);
    int x_pel;
    int y_pel;
    int quad;
    x_pel = 0;
    y_pel = 0;
    for (int size = 32; size >= 8; size = size / 2) begin
        quad  = (int'(idx) / ((size / 8) * (size / 8))) % 4;   // 16, 4 or 1 blocks each
        x_pel += (quad % 2) * size;
        y_pel += (quad / 2) * size;
    end
    return {4'(x_pel / 4), 4'(y_pel / 4)};
endfunction

`endif

// ==== tb_fme_satd_gen.sv ====
// *******************************************************************
// testbench of the fme satd stage
// table of blocks driven on all lanes, results checked against a model
// *******************************************************************
`timescale 1ns/10ps

module tb_fme_satd_gen import satd_pkg::*; ();

    localparam int PW    = 8;
    localparam int NC    = 9;
    localparam int N_ENT = 8;
    localparam int CLK_T = 40;

    // kind 0 zero difference, 1 constant offset, 2 random
    // exp -1 takes the model value, ovl 1 starts the next block right after row 7
    localparam int T_IDX  [N_ENT] = '{0, 45, 22, 63, 9, 50, 37, 18};
    localparam int T_KIND [N_ENT] = '{0, 1, 1, 2, 2, 1, 2, 0};
    localparam int T_OFF  [N_ENT] = '{0, 5, -12, 0, 0, 60, 0, 0};
    localparam int T_OVL  [N_ENT] = '{0, 0, 0, 1, 1, 1, 0, 0};
    localparam int T_EXP  [N_ENT] = '{0, 80, 192, -1, -1, 960, -1, 0};   // 16*|d|

    logic                                 clk;
    logic                                 rstn;
    logic                                 satd_start_i;
    logic [BLK_IDX_W-1:0]                 blk_idx_i;
    logic                                 ip_ready_i;
    logic [READ_PELS-1:0][PW-1:0]         cur_pel_i;
    logic [NC-1:0]                        candi_valid_i;
    logic [NC-1:0][ROW_PELS-1:0][PW-1:0]  candi_pixels_i;
    logic                                 cur_rden_o;
    logic [3:0]                           cur_4x4_x_o;
    logic [3:0]                           cur_4x4_y_o;
    logic [4:0]                           cur_4x4_idx_o;
    logic [BLK_IDX_W-1:0]                 blk_idx_o;
    logic [PW+SATD_EXTRA-1:0]             satd_o [NC];
    logic                                 satd_valid_o;

    int seed  = 32'hc9d4;
    int n_err = 0;
    int n_chk = 0;
    int exp_satd [N_ENT][NC];

    `include "tb_satd_model.svh"

    blk_t cur_blk;
    blk_t cand_blk [NC];

    fme_satd_gen #(.PIXEL_WIDTH(PW), .NUM_CANDI(NC)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_T/2) clk = ~clk;
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_chk++;
        if (got !== exp) begin
            n_err++;
            $display("error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic step_clk();
        @(posedge clk);
        #2;
    endtask

    // current block and every candidate of entry e, plus expected satd
    task automatic make_blocks(input int e);
        for (int r = 0; r < BLK_ROWS; r++) begin
            for (int c = 0; c < ROW_PELS; c++) begin
                cur_blk[r][c] = (T_KIND[e] == 1) ? 64 + ($random(seed) & 127)
                                                 : $random(seed) & 255;   // offsets stay in range
                for (int n = 0; n < NC; n++) begin
                    cand_blk[n][r][c] = (T_KIND[e] == 2) ? $random(seed) & 255
                                                         : cur_blk[r][c] + T_OFF[e];
                end
            end
        end
        for (int n = 0; n < NC; n++) begin
            exp_satd[e][n] = (T_EXP[e] >= 0) ? T_EXP[e] : satd_ref(cur_blk, cand_blk[n]);
        end
    endtask

    // valid is high in the second cycle after the row 7 edge
    task automatic collect_result(input int e);
        @(posedge clk);
        #1;
        check_val("satd_valid_o", satd_valid_o, 1);
        check_val("blk_idx_o", blk_idx_o, T_IDX[e]);
        for (int n = 0; n < NC; n++) begin
            check_val($sformatf("satd_o[%0d]", n), satd_o[n], exp_satd[e][n]);
        end
        @(posedge clk);
        #1;
        check_val("satd_valid_o", satd_valid_o, 0);   // single cycle pulse
    endtask

    // *******************************************************************
    // one table entry, start, two reads, eight rows
    // *******************************************************************
    task automatic run_block(input int e);
        logic [7:0] xy;
        make_blocks(e);
        satd_start_i = 1'b1;
        blk_idx_i    = BLK_IDX_W'(T_IDX[e]);
        step_clk();
        satd_start_i = 1'b0;
        xy = zigzag_xy(BLK_IDX_W'(T_IDX[e]));
        check_val("cur_4x4_x_o", cur_4x4_x_o, xy[7:4]);
        check_val("cur_4x4_y_o", cur_4x4_y_o, xy[3:0]);
        for (int h = 0; h < 2; h++) begin
            ip_ready_i = 1'b1;
            #1;
            check_val("cur_rden_o", cur_rden_o, 1);
            check_val("cur_4x4_idx_o", cur_4x4_idx_o, 4 * h);
            step_clk();
            ip_ready_i = 1'b0;
            // first row of the half in the top pixels
            for (int i = 0; i < READ_PELS; i++) begin
                cur_pel_i[i] = PW'(cur_blk[4 * h + 3 - i / ROW_PELS][i % ROW_PELS]);
            end
            #1;
            check_val("cur_rden_o", cur_rden_o, 0);
            step_clk();
        end
        candi_valid_i = '1;
        for (int r = 0; r < BLK_ROWS; r++) begin
            for (int n = 0; n < NC; n++) begin
                for (int c = 0; c < ROW_PELS; c++) begin
                    candi_pixels_i[n][c] = PW'(cand_blk[n][r][c]);
                end
            end
            step_clk();
        end
        candi_valid_i = '0;
        if (T_OVL[e] != 0) begin
            fork
                collect_result(e);   // next block starts in this cycle
            join_none
        end else begin
            collect_result(e);
            #1;
        end
    endtask

    // entries take about 15 cycles each
    initial begin
        #((N_ENT * 40 + 8) * CLK_T);
        $display("timeout, the test table did not complete");
        $display("checks %0d errors %0d", n_chk, n_err);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        rstn           = 1'b0;
        satd_start_i   = 1'b0;
        blk_idx_i      = '0;
        ip_ready_i     = 1'b0;
        cur_pel_i      = '0;
        candi_valid_i  = '0;
        candi_pixels_i = '0;
        repeat (8) @(posedge clk);
        #2;
        rstn = 1'b1;
        // idle state
        check_val("satd_valid_o", satd_valid_o, 0);
        check_val("cur_rden_o", cur_rden_o, 0);
        for (int n = 0; n < NC; n++) begin
            check_val($sformatf("satd_o[%0d]", n), satd_o[n], 0);
        end
        step_clk();
        for (int e = 0; e < N_ENT; e++) begin
            run_block(e);
        end
        $display("checks %0d errors %0d", n_chk, n_err);
        if (n_err == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== fme_satd_gen.sv ====
// *******************************************************************
// fme satd stage top
// hadamard satd of NUM_CANDI candidates against one 8x8 current block
// *******************************************************************
`timescale 1ns/10ps

module fme_satd_gen import satd_pkg::*; #(
    parameter int PIXEL_WIDTH = 8,
    parameter int NUM_CANDI   = 9
) (
    input  logic                                                clk,
    input  logic                                                rstn,
    input  logic                                                satd_start_i,
    input  logic [BLK_IDX_W-1:0]                                blk_idx_i,
    input  logic                                                ip_ready_i,
    input  logic [READ_PELS-1:0][PIXEL_WIDTH-1:0]               cur_pel_i,
    input  logic [NUM_CANDI-1:0]                                candi_valid_i,
    input  logic [NUM_CANDI-1:0][ROW_PELS-1:0][PIXEL_WIDTH-1:0] candi_pixels_i,
    output logic                                                cur_rden_o,
    output logic [3:0]                                          cur_4x4_x_o,
    output logic [3:0]                                          cur_4x4_y_o,
    output logic [4:0]                                          cur_4x4_idx_o,
    output logic [BLK_IDX_W-1:0]                                blk_idx_o,
    output logic [PIXEL_WIDTH+SATD_EXTRA-1:0]                   satd_o [NUM_CANDI],
    output logic                                                satd_valid_o
);

    logic [BLK_ROWS-1:0][ROW_PELS-1:0][PIXEL_WIDTH-1:0] cur_rows;
    logic                                               lane_valid [NUM_CANDI];

    assign cur_rden_o   = ip_ready_i;                  // read straight on ip ready
    assign satd_valid_o = lane_valid[NUM_CANDI-1];     // all lanes run in step

    blk_ctrl u_blk_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .satd_start_i (satd_start_i),
        .blk_idx_i    (blk_idx_i),
        .satd_valid_i (satd_valid_o),
        .blk_idx_o    (blk_idx_o),
        .cur_4x4_x_o  (cur_4x4_x_o),
        .cur_4x4_y_o  (cur_4x4_y_o)
    );

    cur_blk_buf #(
        .PIXEL_WIDTH (PIXEL_WIDTH)
    ) u_cur_blk_buf (
        .clk           (clk),
        .rstn          (rstn),
        .rden_i        (ip_ready_i),
        .cur_pel_i     (cur_pel_i),
        .cur_4x4_idx_o (cur_4x4_idx_o),
        .cur_rows_o    (cur_rows)
    );

    // *******************************************************************
    // one lane and one satd core per candidate
    // *******************************************************************
    for (genvar n = 0; n < NUM_CANDI; n++) begin : g_lane
        row_pair_if #(.PIXEL_WIDTH(PIXEL_WIDTH)) rp_if ();

        candi_lane #(
            .PIXEL_WIDTH (PIXEL_WIDTH)
        ) u_lane (
            .clk          (clk),
            .rstn         (rstn),
            .satd_start_i (satd_start_i),
            .cand_valid_i (candi_valid_i[n]),
            .cand_row_i   (candi_pixels_i[n]),
            .cur_rows_i   (cur_rows),
            .rp           (rp_if)
        );

        satd_8x8 #(
            .PIXEL_WIDTH (PIXEL_WIDTH)
        ) u_satd (
            .clk          (clk),
            .rstn         (rstn),
            .rp           (rp_if),
            .satd_o       (satd_o[n]),
            .satd_valid_o (lane_valid[n])
        );
    end

endmodule

// ==== satd_8x8.sv ====
// *******************************************************************
// 8x8 hadamard satd core
// row transform, column transform by signed accumulation, abs sum
// *******************************************************************
`timescale 1ns/10ps

module satd_8x8 import satd_pkg::*; #(
    parameter int PIXEL_WIDTH = 8
) (
    input  logic                                clk,
    input  logic                                rstn,
    row_pair_if.core                            rp,
    output logic [PIXEL_WIDTH+SATD_EXTRA-1:0]   satd_o,
    output logic                                satd_valid_o
);

    localparam int SATD_W = PIXEL_WIDTH + SATD_EXTRA;
    localparam int COEF_W = PIXEL_WIDTH + ROW_IDX_W + 1;
    localparam int ACC_W  = PIXEL_WIDTH + 2*ROW_IDX_W + 1;   // 64x gain plus sign
    localparam int SUM_W  = SATD_W + 2;                      // before the >>2

    logic signed [COEF_W-1:0] coef [ROW_PELS];
    logic signed [ACC_W-1:0]  term [BLK_ROWS][ROW_PELS];
    logic signed [ACC_W-1:0]  acc  [BLK_ROWS][ROW_PELS];   // (j,k) spectrum
    logic        [SUM_W-1:0]  abs_sum;
    logic        [SUM_W-1:0]  rounded;
    logic                     last_row;
    logic                     done_q;   // block complete in acc

    hadamard_row8 #(
        .PIXEL_WIDTH (PIXEL_WIDTH)
    ) u_hadamard (
        .cur_row_i  (rp.cur_row),
        .cand_row_i (rp.cand_row),
        .coef_o     (coef)
    );

    // *******************************************************************
    // column transform
    // *******************************************************************
    // row r enters output row j with sign (-1)^popcount(j & r)
    always_comb begin
        logic neg;
        for (int j = 0; j < BLK_ROWS; j++) begin
            neg = ^(ROW_IDX_W'(j) & rp.row_idx);
            for (int k = 0; k < ROW_PELS; k++) begin
                term[j][k] = neg ? -coef[k] : coef[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rp.valid) begin
            for (int j = 0; j < BLK_ROWS; j++) begin
                for (int k = 0; k < ROW_PELS; k++) begin
                    if (rp.row_idx == '0) begin
                        acc[j][k] <= term[j][k];   // first row loads
                    end else begin
                        acc[j][k] <= acc[j][k] + term[j][k];
                    end
                end
            end
        end
    end

    // *******************************************************************
    // absolute sum and result
    // *******************************************************************
    always_comb begin
        logic signed [ACC_W-1:0] mag;
        abs_sum = '0;
        for (int j = 0; j < BLK_ROWS; j++) begin
            for (int k = 0; k < ROW_PELS; k++) begin
                mag     = acc[j][k][ACC_W-1] ? -acc[j][k] : acc[j][k];
                abs_sum = abs_sum + SUM_W'($unsigned(mag));
            end
        end
    end

    assign rounded  = (abs_sum + SUM_W'(2)) >> 2;
    assign last_row = rp.valid && (rp.row_idx == ROW_IDX_W'(BLK_ROWS - 1));

    // acc is free again once done_q is seen, next block may overwrite it
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            done_q       <= 1'b0;
            satd_valid_o <= 1'b0;
            satd_o       <= '0;
        end else begin
            done_q       <= last_row;
            satd_valid_o <= done_q;
            if (done_q) begin
                satd_o <= rounded[SATD_W-1:0];   // held until next block
            end
        end
    end

endmodule

// ==== hadamard_row8.sv ====
// *******************************************************************
// 8-point hadamard transform of one row difference
// three butterfly stages, coefficient k in sylvester order
// *******************************************************************
`timescale 1ns/10ps

module hadamard_row8 import satd_pkg::*; #(
    parameter int PIXEL_WIDTH = 8
) (
    input  logic        [ROW_PELS-1:0][PIXEL_WIDTH-1:0] cur_row_i,
    input  logic        [ROW_PELS-1:0][PIXEL_WIDTH-1:0] cand_row_i,
    output logic signed [PIXEL_WIDTH+ROW_IDX_W:0]       coef_o [ROW_PELS]
);

    localparam int COEF_W = PIXEL_WIDTH + ROW_IDX_W + 1;   // 8x gain plus sign

    // stage 0 is the difference, stage ROW_IDX_W the spectrum
    logic signed [COEF_W-1:0] st [ROW_IDX_W+1][ROW_PELS];

    for (genvar c = 0; c < ROW_PELS; c++) begin : g_diff
        assign st[0][c] = COEF_W'($signed({1'b0, cand_row_i[c]}))
                        - COEF_W'($signed({1'b0, cur_row_i[c]}));
    end

    // *******************************************************************
    // butterflies, stage s pairs pixels 2**s apart
    // *******************************************************************
    for (genvar s = 0; s < ROW_IDX_W; s++) begin : g_stage
        for (genvar i = 0; i < ROW_PELS; i++) begin : g_pel
            localparam int DIST = 1 << s;
            if ((i & DIST) == 0) begin : g_sum
                assign st[s+1][i] = st[s][i] + st[s][i+DIST];
            end else begin : g_dif
                assign st[s+1][i] = st[s][i-DIST] - st[s][i];
            end
        end
    end

    for (genvar k = 0; k < ROW_PELS; k++) begin : g_out
        assign coef_o[k] = st[ROW_IDX_W][k];
    end

endmodule

// ==== candi_lane.sv ====
// *******************************************************************
// candidate lane
// counts candidate rows and pairs each with its current row
// *******************************************************************
`timescale 1ns/10ps

module candi_lane import satd_pkg::*; #(
    parameter int PIXEL_WIDTH = 8
) (
    input  logic                                               clk,
    input  logic                                               rstn,
    input  logic                                               satd_start_i,
    input  logic                                               cand_valid_i,
    input  logic [ROW_PELS-1:0][PIXEL_WIDTH-1:0]               cand_row_i,
    input  logic [BLK_ROWS-1:0][ROW_PELS-1:0][PIXEL_WIDTH-1:0] cur_rows_i,
    row_pair_if.lane                                           rp
);

    logic [ROW_IDX_W-1:0] row_cnt_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            row_cnt_q <= '0;
        end else if (satd_start_i) begin
            row_cnt_q <= '0;
        end else if (cand_valid_i) begin
            row_cnt_q <= row_cnt_q + 1'b1;   // wraps to 0 after row 7
        end
    end

    assign rp.valid    = cand_valid_i;
    assign rp.row_idx  = row_cnt_q;
    assign rp.cur_row  = cur_rows_i[row_cnt_q];   // matching current row
    assign rp.cand_row = cand_row_i;

endmodule

// ==== cur_blk_buf.sv ====
// *******************************************************************
// current block buffer
// collects the 64 current pixels from two 32-pixel reads
// *******************************************************************
`timescale 1ns/10ps

module cur_blk_buf import satd_pkg::*; #(
    parameter int PIXEL_WIDTH = 8
) (
    input  logic                                               clk,
    input  logic                                               rstn,
    input  logic                                               rden_i,
    input  logic [READ_PELS-1:0][PIXEL_WIDTH-1:0]              cur_pel_i,
    output logic [4:0]                                         cur_4x4_idx_o,
    output logic [BLK_ROWS-1:0][ROW_PELS-1:0][PIXEL_WIDTH-1:0] cur_rows_o
);

    localparam int HALF_ROWS = READ_PELS / ROW_PELS;   // rows per read

    logic pel_vld_q;   // memory data is on cur_pel_i this cycle
    logic half_q;      // set while the lower half is to be read

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pel_vld_q <= 1'b0;
            half_q    <= 1'b0;
        end else begin
            pel_vld_q <= rden_i;
            if (rden_i) begin
                half_q <= ~half_q;
            end
        end
    end

    // first row of each read sits in the top bits
    always_ff @(posedge clk) begin
        if (pel_vld_q) begin
            for (int r = 0; r < HALF_ROWS; r++) begin
                if (half_q) begin
                    cur_rows_o[r] <= cur_pel_i[(HALF_ROWS-1-r)*ROW_PELS +: ROW_PELS];
                end else begin
                    cur_rows_o[HALF_ROWS+r] <= cur_pel_i[(HALF_ROWS-1-r)*ROW_PELS +: ROW_PELS];
                end
            end
        end
    end

    assign cur_4x4_idx_o = {2'b00, half_q, 2'b00};   // 0 or 4

endmodule

// ==== blk_ctrl.sv ====
// *******************************************************************
// block control of the fme satd stage
// ping-pong block index and zig-zag to raster read address
// *******************************************************************
`timescale 1ns/10ps

module blk_ctrl import satd_pkg::*; (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 satd_start_i,   // opens a new 8x8 block
    input  logic [BLK_IDX_W-1:0] blk_idx_i,
    input  logic                 satd_valid_i,   // result of the oldest block is out
    output logic [BLK_IDX_W-1:0] blk_idx_o,
    output logic [3:0]           cur_4x4_x_o,
    output logic [3:0]           cur_4x4_y_o
);

    logic [BLK_IDX_W-1:0] idx_q [2];   // two blocks may be in flight
    logic                 in_sel_q;    // entry taken by the next start
    logic                 out_sel_q;   // entry shown with the next result
    logic [BLK_IDX_W-1:0] cur_idx;
    logic [1:0]           idx32;
    logic [1:0]           idx16;
    logic [1:0]           idx08;

    // *******************************************************************
    // index ping-pong
    // *******************************************************************
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            idx_q[0] <= '0;
            idx_q[1] <= '0;
            in_sel_q <= 1'b0;
        end else if (satd_start_i) begin
            idx_q[in_sel_q] <= blk_idx_i;
            in_sel_q        <= ~in_sel_q;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_sel_q <= 1'b0;
        end else if (satd_valid_i) begin
            out_sel_q <= ~out_sel_q;
        end
    end

    assign blk_idx_o = idx_q[out_sel_q];
    assign cur_idx   = idx_q[~in_sel_q];   // most recent start

    // *******************************************************************
    // zig-zag to raster, in 4x4 units
    // *******************************************************************
    assign idx32 = cur_idx[5:4];
    assign idx16 = cur_idx[3:2];
    assign idx08 = cur_idx[1:0];

    // low bit of each quadrant pair is x, high bit is y
    assign cur_4x4_x_o = {idx32[0], idx16[0], idx08[0], 1'b0};
    assign cur_4x4_y_o = {idx32[1], idx16[1], idx08[1], 1'b0};

endmodule

// ==== row_pair_if.sv ====
// *******************************************************************
// row pair bus from a candidate lane into its satd core
// one current row and one candidate row per valid strobe
// *******************************************************************
`timescale 1ns/10ps

interface row_pair_if import satd_pkg::*; #(
    parameter int PIXEL_WIDTH = 8
) ();

    logic                                  valid;     // row taken on every edge it is high
    logic [ROW_IDX_W-1:0]                  row_idx;   // row inside the 8x8 block
    logic [ROW_PELS-1:0][PIXEL_WIDTH-1:0]  cur_row;
    logic [ROW_PELS-1:0][PIXEL_WIDTH-1:0]  cand_row;

    // no back-pressure in either direction
    modport lane (
        output valid, row_idx, cur_row, cand_row
    );

    modport core (
        input  valid, row_idx, cur_row, cand_row
    );

endinterface

// ==== satd_pkg.sv ====
// *******************************************************************
// shared constants of the fme satd stage
// 8x8 block geometry and index widths
// *******************************************************************

package satd_pkg;

    // block geometry
    localparam int ROW_PELS  = 8;           // pixels per block row
    localparam int BLK_ROWS  = 8;           // rows per block

    // index widths
    localparam int ROW_IDX_W = 3;           // row counter, 0..7
    localparam int BLK_IDX_W = 6;           // zig-zag 8x8 index inside a 64x64 lcu

    // current block memory reads
    localparam int READ_PELS = 32;          // half a block per read

    // satd grows this many bits over the pixel width
    localparam int SATD_EXTRA = 10;

endpackage
